/* dv/peripheral_bus_sva.sv */
//////////////////////////////
// peripheral bus assertions
// response hold under back-pressure,
// quiet outputs during reset
//////////////////////////////
`default_nettype none

module peripheral_bus_sva (
    input logic                          clock_i,
    input logic                          rst_i,
    input logic                          aw_ready_i,
    input logic                          w_ready_i,
    input logic                          ar_ready_i,
    input logic                          b_valid_i,
    input logic                          b_ready_i,
    input logic [1:0]                    b_resp_i,
    input logic                          r_valid_i,
    input logic                          r_ready_i,
    input logic [periph_pkg::DATA_W-1:0] r_data_i,
    input logic [1:0]                    r_resp_i,
    input logic [2:0]                    int_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // write response held until taken
    b_hold_a : assert property (@(posedge clock_i) disable iff (rst_i)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
        else $error("write response dropped or changed before b_ready");

    // read response held with data
    r_hold_a : assert property (@(posedge clock_i) disable iff (rst_i)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
        else $error("read response dropped or changed before r_ready");

    // second reset cycle on, everything low
    reset_quiet_a : assert property (@(posedge clock_i)
        rst_i && $past(rst_i) |-> !b_valid_i && !r_valid_i && !aw_ready_i
                                 && !w_ready_i && !ar_ready_i && (int_i == 3'b000))
        else $error("valid, ready or int_o high during reset");

endmodule : peripheral_bus_sva

bind peripheral_bus peripheral_bus_sva sva_u (
    .clock_i    ( clock_i           ),
    .rst_i      ( rst_i             ),
    .aw_ready_i ( s_axil_aw_ready_o ),
    .w_ready_i  ( s_axil_w_ready_o  ),
    .ar_ready_i ( s_axil_ar_ready_o ),
    .b_valid_i  ( s_axil_b_valid_o  ),
    .b_ready_i  ( s_axil_b_ready_i  ),
    .b_resp_i   ( s_axil_b_resp_o   ),
    .r_valid_i  ( s_axil_r_valid_o  ),
    .r_ready_i  ( s_axil_r_ready_i  ),
    .r_data_i   ( s_axil_r_data_o   ),
    .r_resp_i   ( s_axil_r_resp_o   ),
    .int_i      ( int_o             )
);

`default_nettype wire

/* dv/peripheral_testdata.txt */
// op: 1 write, 2 read, 3 drive gpio_in, 4 wait for int_o, 0 end
// columns: op addr data resp (data = write word, expected read word, pins or int_o)
2 00000000 00000000 0  // GPIO_OUT after reset
1 00000000 000000A5 0
2 00000000 000000A5 0
1 0000000C 000000FF 0  // GPIO_IEN all pins
3 00000000 0000005A 0  // pins change
4 00000000 00000001 0
2 00000008 0000005A 0  // GPIO_STAT changed bits
2 00000004 0000005A 0  // GPIO_IN new value
1 00000008 0000005A 0  // w1c status
4 00000000 00000000 0
2 00000008 00000000 0
1 00001004 00000010 0  // tim0 LOAD
1 00001000 00000005 0  // tim0 one-shot, EN and IEN
4 00000000 00000002 0
2 00001008 00000000 0  // COUNT held at zero
2 00001000 00000004 0  // EN cleared, IEN kept
2 0000100C 00000001 0
1 0000100C 00000001 0  // clear tim0 STAT
4 00000000 00000000 0
1 00002004 00000040 0  // tim1 LOAD
1 00002000 00000007 0  // tim1 auto-reload, EN and IEN
4 00000000 00000004 0
1 0000200C 00000001 0  // clear tim1 STAT
2 0000200C 00000000 0
4 00000000 00000004 0  // fires again, tim0 quiet
1 00002000 00000000 0  // stop tim1
1 0000200C 00000001 0
4 00000000 00000000 0
1 00003000 DEADBEEF 3  // unmapped slot 3
2 00003004 00000000 3
2 0000F00C 00000000 3
1 0000F000 12345678 3
2 00000010 00000000 0  // unknown GPIO offset
0 00000000 00000000 0

/* dv/tb_peripheral_bus.sv */
//////////////////////////////
// peripheral bus testbench
// AXI-lite master driven from a data file,
// random response back-pressure
//////////////////////////////
`default_nettype none

module tb_peripheral_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned HS_LIMIT  = 20;        // cycles for one handshake
    localparam int unsigned INT_LIMIT = 500;       // cycles for an int_o pattern
    localparam int unsigned MEM_WORDS = 512;       // four words per operation
    localparam logic [3:0]  OP_END    = 4'h0;
    localparam logic [3:0]  OP_WRITE  = 4'h1;
    localparam logic [3:0]  OP_READ   = 4'h2;
    localparam logic [3:0]  OP_PINS   = 4'h3;
    localparam logic [3:0]  OP_IRQ    = 4'h4;

    logic        clock = 1'b0;
    logic        rst;
    logic [31:0] aw_addr, w_data, ar_addr, r_data;
    logic        aw_valid, aw_ready, w_valid, w_ready;
    logic        b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready;
    logic [1:0]  b_resp, r_resp;
    logic [7:0]  gpio_in, gpio_out;
    logic [2:0]  irq_vec;                          // {tim1, tim0, gpio}
    logic [31:0] td_mem [0:MEM_WORDS-1];
    int unsigned checks, errors, timeouts, idx;
    logic        aborted;

    always #5 clock = ~clock;

    peripheral_bus #(
        .NUM_GPIO_IN  ( 8  ),
        .NUM_GPIO_OUT ( 8  ),
        .TIMER_W      ( 32 )
    ) UUT (
        .clock_i           ( clock    ),
        .rst_i             ( rst      ),
        .s_axil_aw_addr_i  ( aw_addr  ),
        .s_axil_aw_valid_i ( aw_valid ),
        .s_axil_aw_ready_o ( aw_ready ),
        .s_axil_w_data_i   ( w_data   ),
        .s_axil_w_valid_i  ( w_valid  ),
        .s_axil_w_ready_o  ( w_ready  ),
        .s_axil_b_resp_o   ( b_resp   ),
        .s_axil_b_valid_o  ( b_valid  ),
        .s_axil_b_ready_i  ( b_ready  ),
        .s_axil_ar_addr_i  ( ar_addr  ),
        .s_axil_ar_valid_i ( ar_valid ),
        .s_axil_ar_ready_o ( ar_ready ),
        .s_axil_r_data_o   ( r_data   ),
        .s_axil_r_resp_o   ( r_resp   ),
        .s_axil_r_valid_o  ( r_valid  ),
        .s_axil_r_ready_i  ( r_ready  ),
        .gpio_in_i         ( gpio_in  ),
        .gpio_out_o        ( gpio_out ),
        .int_o             ( irq_vec  )
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        aborted = 1'b1;                            // stop walking the data file
        $display("Timeout at %0t: %s did not happen in time", $time, what);
    endtask

    // 0 to 3 cycles with ready low
    task automatic stall_ready();
        int unsigned n;
        n = $urandom % 4;
        repeat (n) @(negedge clock);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int unsigned cycles;
        logic        accepted;
        logic [1:0]  resp;
        aw_addr  = addr;
        w_data   = data;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        cycles   = 0;
        #1;                                        // ready settles after the drive
        while (!(aw_ready && w_ready) && cycles < HS_LIMIT) begin
            @(negedge clock);
            #1;
            cycles++;
        end
        accepted = aw_ready && w_ready;            // both ready in one cycle
        @(negedge clock);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        if (!accepted) begin
            report_timeout($sformatf("write handshake for 0x%08h", addr));
            return;
        end
        check_value(32'(b_valid), 32'h1, "b_valid one cycle after handshake");
        stall_ready();
        resp    = b_resp;
        b_ready = 1'b1;
        @(negedge clock);
        b_ready = 1'b0;
        check_value(32'(resp), 32'(exp_resp), $sformatf("b_resp of write 0x%08h", addr));
        check_value(32'(b_valid), 32'h0, "b_valid after accept");
        // GPIO_OUT drives the pins with the low byte
        if (addr[15:0] == 16'h0000) begin
            check_value(32'(gpio_out), data & 32'h0000_00FF, "gpio_out_o");
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        int unsigned cycles;
        logic        accepted;
        logic [31:0] data;
        logic [1:0]  resp;
        ar_addr  = addr;
        ar_valid = 1'b1;
        cycles   = 0;
        #1;
        while (!ar_ready && cycles < HS_LIMIT) begin
            @(negedge clock);
            #1;
            cycles++;
        end
        accepted = ar_ready;
        @(negedge clock);
        ar_valid = 1'b0;
        if (!accepted) begin
            report_timeout($sformatf("read handshake for 0x%08h", addr));
            return;
        end
        check_value(32'(r_valid), 32'h1, "r_valid one cycle after handshake");
        stall_ready();
        data    = r_data;                          // still held under back-pressure
        resp    = r_resp;
        r_ready = 1'b1;
        @(negedge clock);
        r_ready = 1'b0;
        check_value(data, exp_data, $sformatf("r_data of read 0x%08h", addr));
        check_value(32'(resp), 32'(exp_resp), $sformatf("r_resp of read 0x%08h", addr));
        check_value(32'(r_valid), 32'h0, "r_valid after accept");
    endtask

    task automatic wait_irq(input logic [2:0] expected);
        int unsigned cycles;
        cycles = 0;
        while (irq_vec !== expected && cycles < INT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (irq_vec !== expected) begin
            report_timeout($sformatf("int_o reaching %03b", expected));
        end
    endtask

    initial begin
        void'($urandom(11861));
        rst      = 1'b1;
        aw_addr  = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_addr  = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        gpio_in  = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        aborted  = 1'b0;
        idx      = 0;
        $readmemh("dv/peripheral_testdata.txt", td_mem);
        repeat (3) @(negedge clock);               // three reset edges
        rst = 1'b0;
        @(negedge clock);

        while (!aborted && idx + 3 < MEM_WORDS && td_mem[idx][3:0] != OP_END) begin
            case (td_mem[idx][3:0])
                OP_WRITE: bus_write(td_mem[idx+1], td_mem[idx+2], td_mem[idx+3][1:0]);
                OP_READ:  bus_read(td_mem[idx+1], td_mem[idx+2], td_mem[idx+3][1:0]);
                OP_PINS: begin
                    gpio_in = td_mem[idx+2][7:0];
                    @(negedge clock);
                end
                OP_IRQ:   wait_irq(td_mem[idx+2][2:0]);
                default: begin
                    errors++;
                    aborted = 1'b1;
                    $display("Unknown operation %0h in test data at word %0d",
                             td_mem[idx][3:0], idx);
                end
            endcase
            idx += 4;
        end

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_peripheral_bus

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the peripheral bus testbench with Verilator, run it, and
# decide the result from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_peripheral_bus

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_peripheral_bus --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim.f */
verilog/periph_pkg.sv
verilog/axilite_if.sv
verilog/timer_counter.sv
verilog/timer_regs.sv
verilog/gpio_regs.sv
verilog/periph_decoder.sv
verilog/peripheral_bus.sv
dv/peripheral_bus_sva.sv
dv/tb_peripheral_bus.sv

/* verilog/axilite_if.sv */
//////////////////////////////
// AXI-lite link between decoder
// and one register block
//////////////////////////////
`default_nettype none

interface axilite_if;
    import periph_pkg::*;

    logic [ADDR_W-1:0] aw_addr;
    logic              aw_valid;
    logic              aw_ready;
    logic [DATA_W-1:0] w_data;                     // always a full word
    logic              w_valid;
    logic              w_ready;
    axi_resp_e         b_resp;
    logic              b_valid;
    logic              b_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              ar_valid;
    logic              ar_ready;
    logic [DATA_W-1:0] r_data;
    axi_resp_e         r_resp;
    logic              r_valid;
    logic              r_ready;

    modport master (
        output aw_addr, aw_valid, w_data, w_valid, b_ready, ar_addr, ar_valid, r_ready,
        input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
    );

    modport slave (
        input  aw_addr, aw_valid, w_data, w_valid, b_ready, ar_addr, ar_valid, r_ready,
        output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
    );

endinterface : axilite_if

`default_nettype wire

/* verilog/gpio_regs.sv */
//////////////////////////////
// GPIO register block
// output latch, 2-flop input sync,
// change status with w1c and irq enable
//////////////////////////////
`default_nettype none

module gpio_regs #(
    parameter int unsigned NUM_IN  = 8,
    parameter int unsigned NUM_OUT = 8
) (
    input  logic               clock_i,
    input  logic               rst_i,
    axilite_if.slave           bus_s,
    input  logic [NUM_IN-1:0]  gpio_in_i,
    output logic [NUM_OUT-1:0] gpio_out_o,
    output logic               irq_o
);
    import periph_pkg::*;

    periph_addr_u       wr_addr;
    periph_addr_u       rd_addr;
    logic               wr_hs, rd_hs;
    logic               b_valid_q, r_valid_q;
    logic [DATA_W-1:0]  r_data_q;
    logic [DATA_W-1:0]  rd_word;
    logic [NUM_OUT-1:0] out_q;
    logic [NUM_IN-1:0]  meta_q, sync_q, prev_q;   // sync chain + edge detect
    logic [NUM_IN-1:0]  stat_q, ien_q;
    logic [NUM_IN-1:0]  changed, stat_clr;

    assign wr_addr.raw = bus_s.aw_addr;
    assign rd_addr.raw = bus_s.ar_addr;

    // one transaction per channel at a time
    assign wr_hs = bus_s.aw_valid & bus_s.w_valid & ~b_valid_q;
    assign rd_hs = bus_s.ar_valid & ~r_valid_q;

    assign bus_s.aw_ready = wr_hs;
    assign bus_s.w_ready  = wr_hs;
    assign bus_s.b_valid  = b_valid_q;
    assign bus_s.b_resp   = RESP_OKAY;             // unknown offsets are ignored
    assign bus_s.ar_ready = rd_hs;
    assign bus_s.r_valid  = r_valid_q;
    assign bus_s.r_data   = r_data_q;
    assign bus_s.r_resp   = RESP_OKAY;

    assign changed    = sync_q ^ prev_q;
    assign stat_clr   = (wr_hs && wr_addr.fld.offset == GPIO_STAT_OFS) ?
                        bus_s.w_data[NUM_IN-1:0] : '0;
    assign gpio_out_o = out_q;
    assign irq_o      = |(stat_q & ien_q);         // same cycle as status

    always_comb begin
        case (rd_addr.fld.offset)
            GPIO_OUT_OFS:  rd_word = DATA_W'(out_q);
            GPIO_IN_OFS:   rd_word = DATA_W'(sync_q);
            GPIO_STAT_OFS: rd_word = DATA_W'(stat_q);
            GPIO_IEN_OFS:  rd_word = DATA_W'(ien_q);
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            meta_q    <= '0;
            sync_q    <= '0;
            prev_q    <= '0;
            out_q     <= '0;
            stat_q    <= '0;
            ien_q     <= '0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            r_data_q  <= '0;
        end else begin
            meta_q <= gpio_in_i;
            sync_q <= meta_q;
            prev_q <= sync_q;
            stat_q <= (stat_q & ~stat_clr) | changed;  // new edge beats clear
            if (wr_hs && wr_addr.fld.offset == GPIO_OUT_OFS) begin
                out_q <= bus_s.w_data[NUM_OUT-1:0];
            end
            if (wr_hs && wr_addr.fld.offset == GPIO_IEN_OFS) begin
                ien_q <= bus_s.w_data[NUM_IN-1:0];
            end
            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (bus_s.b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_hs) begin
                r_valid_q <= 1'b1;
                r_data_q  <= rd_word;              // held until r_ready
            end else if (bus_s.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

endmodule : gpio_regs

`default_nettype wire

/* verilog/periph_decoder.sv */
//////////////////////////////
// AXI-lite slot decoder
// routes each request to one block by
// address bits 15..12, steers the response
// back, answers DECERR for empty slots
//////////////////////////////
`default_nettype none

module periph_decoder (
    input  logic                          clock_i,
    input  logic                          rst_i,
    input  logic [periph_pkg::ADDR_W-1:0] s_axil_aw_addr_i,
    input  logic                          s_axil_aw_valid_i,
    output logic                          s_axil_aw_ready_o,
    input  logic [periph_pkg::DATA_W-1:0] s_axil_w_data_i,
    input  logic                          s_axil_w_valid_i,
    output logic                          s_axil_w_ready_o,
    output periph_pkg::axi_resp_e         s_axil_b_resp_o,
    output logic                          s_axil_b_valid_o,
    input  logic                          s_axil_b_ready_i,
    input  logic [periph_pkg::ADDR_W-1:0] s_axil_ar_addr_i,
    input  logic                          s_axil_ar_valid_i,
    output logic                          s_axil_ar_ready_o,
    output logic [periph_pkg::DATA_W-1:0] s_axil_r_data_o,
    output periph_pkg::axi_resp_e         s_axil_r_resp_o,
    output logic                          s_axil_r_valid_o,
    input  logic                          s_axil_r_ready_i,
    axilite_if.master                     gpio_m,
    axilite_if.master                     tim0_m,
    axilite_if.master                     tim1_m
);
    import periph_pkg::*;

    localparam logic [1:0] SEL_ERR = 2'd3;         // internal error responder

    // slot number to port index
    function automatic logic [1:0] slot_sel(input logic [ADDR_W-1:0] addr);
        periph_addr_u a;
        a.raw = addr;
        case (a.fld.slot)
            SLOT_GPIO: slot_sel = 2'd0;
            SLOT_TIM0: slot_sel = 2'd1;
            SLOT_TIM1: slot_sel = 2'd2;
            default:   slot_sel = SEL_ERR;
        endcase
    endfunction

    logic [1:0]        aw_sel, ar_sel;             // slot of the live request
    logic [1:0]        wr_sel_q, rd_sel_q;         // slot owning the response
    logic [3:0]        wr_req, rd_req;             // one-hot, blocked while resp held
    logic [3:0]        wr_own, rd_own;             // one-hot of the latched slot
    logic [3:0]        aw_rdy, w_rdy, b_vld, ar_rdy, r_vld;
    axi_resp_e         b_rsp [4];
    axi_resp_e         r_rsp [4];
    logic [DATA_W-1:0] r_dat [4];
    logic              de_wr_hs, de_rd_hs;
    logic              de_b_valid_q, de_r_valid_q;

    assign aw_sel = slot_sel(s_axil_aw_addr_i);
    assign ar_sel = slot_sel(s_axil_ar_addr_i);
    assign wr_req = s_axil_b_valid_o ? 4'b0000 : (4'b0001 << aw_sel);
    assign rd_req = s_axil_r_valid_o ? 4'b0000 : (4'b0001 << ar_sel);
    assign wr_own = 4'b0001 << wr_sel_q;
    assign rd_own = 4'b0001 << rd_sel_q;

    //////////////////////////////
    // requests out
    //////////////////////////////
    assign gpio_m.aw_addr  = s_axil_aw_addr_i;
    assign gpio_m.aw_valid = s_axil_aw_valid_i & wr_req[0];
    assign gpio_m.w_data   = s_axil_w_data_i;
    assign gpio_m.w_valid  = s_axil_w_valid_i & wr_req[0];
    assign gpio_m.b_ready  = s_axil_b_ready_i & wr_own[0];
    assign gpio_m.ar_addr  = s_axil_ar_addr_i;
    assign gpio_m.ar_valid = s_axil_ar_valid_i & rd_req[0];
    assign gpio_m.r_ready  = s_axil_r_ready_i & rd_own[0];

    assign tim0_m.aw_addr  = s_axil_aw_addr_i;
    assign tim0_m.aw_valid = s_axil_aw_valid_i & wr_req[1];
    assign tim0_m.w_data   = s_axil_w_data_i;
    assign tim0_m.w_valid  = s_axil_w_valid_i & wr_req[1];
    assign tim0_m.b_ready  = s_axil_b_ready_i & wr_own[1];
    assign tim0_m.ar_addr  = s_axil_ar_addr_i;
    assign tim0_m.ar_valid = s_axil_ar_valid_i & rd_req[1];
    assign tim0_m.r_ready  = s_axil_r_ready_i & rd_own[1];

    assign tim1_m.aw_addr  = s_axil_aw_addr_i;
    assign tim1_m.aw_valid = s_axil_aw_valid_i & wr_req[2];
    assign tim1_m.w_data   = s_axil_w_data_i;
    assign tim1_m.w_valid  = s_axil_w_valid_i & wr_req[2];
    assign tim1_m.b_ready  = s_axil_b_ready_i & wr_own[2];
    assign tim1_m.ar_addr  = s_axil_ar_addr_i;
    assign tim1_m.ar_valid = s_axil_ar_valid_i & rd_req[2];
    assign tim1_m.r_ready  = s_axil_r_ready_i & rd_own[2];

    // error responder takes the handshake itself
    assign de_wr_hs = s_axil_aw_valid_i & s_axil_w_valid_i & wr_req[SEL_ERR];
    assign de_rd_hs = s_axil_ar_valid_i & rd_req[SEL_ERR];

    //////////////////////////////
    // responses back
    //////////////////////////////
    assign aw_rdy = {de_wr_hs, tim1_m.aw_ready, tim0_m.aw_ready, gpio_m.aw_ready};
    assign w_rdy  = {de_wr_hs, tim1_m.w_ready, tim0_m.w_ready, gpio_m.w_ready};
    assign b_vld  = {de_b_valid_q, tim1_m.b_valid, tim0_m.b_valid, gpio_m.b_valid};
    assign ar_rdy = {de_rd_hs, tim1_m.ar_ready, tim0_m.ar_ready, gpio_m.ar_ready};
    assign r_vld  = {de_r_valid_q, tim1_m.r_valid, tim0_m.r_valid, gpio_m.r_valid};
    assign b_rsp  = '{gpio_m.b_resp, tim0_m.b_resp, tim1_m.b_resp, RESP_DECERR};
    assign r_rsp  = '{gpio_m.r_resp, tim0_m.r_resp, tim1_m.r_resp, RESP_DECERR};
    assign r_dat  = '{gpio_m.r_data, tim0_m.r_data, tim1_m.r_data, '0};

    assign s_axil_aw_ready_o = aw_rdy[aw_sel];
    assign s_axil_w_ready_o  = w_rdy[aw_sel];
    assign s_axil_b_valid_o  = b_vld[wr_sel_q];
    assign s_axil_b_resp_o   = b_rsp[wr_sel_q];
    assign s_axil_ar_ready_o = ar_rdy[ar_sel];
    assign s_axil_r_valid_o  = r_vld[rd_sel_q];
    assign s_axil_r_resp_o   = r_rsp[rd_sel_q];
    assign s_axil_r_data_o   = r_dat[rd_sel_q];

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            wr_sel_q     <= '0;
            rd_sel_q     <= '0;
            de_b_valid_q <= 1'b0;
            de_r_valid_q <= 1'b0;
        end else begin
            if (s_axil_aw_valid_i && s_axil_aw_ready_o) begin
                wr_sel_q <= aw_sel;                // remember who answers b
            end
            if (s_axil_ar_valid_i && s_axil_ar_ready_o) begin
                rd_sel_q <= ar_sel;
            end
            if (de_wr_hs) begin
                de_b_valid_q <= 1'b1;
            end else if (s_axil_b_ready_i && wr_own[SEL_ERR]) begin
                de_b_valid_q <= 1'b0;
            end
            if (de_rd_hs) begin
                de_r_valid_q <= 1'b1;
            end else if (s_axil_r_ready_i && rd_own[SEL_ERR]) begin
                de_r_valid_q <= 1'b0;
            end
        end
    end

endmodule : periph_decoder

`default_nettype wire

/* verilog/periph_pkg.sv */
//////////////////////////////
// peripheral subsystem package
// bus widths, address map, register
// offsets and response codes
//////////////////////////////
`default_nettype none

package periph_pkg;

    localparam int unsigned ADDR_W = 32;           // one bus word
    localparam int unsigned DATA_W = 32;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11                        // no slave at this slot
    } axi_resp_e;

    // slot = address bits 15..12
    localparam logic [3:0] SLOT_GPIO = 4'd0;
    localparam logic [3:0] SLOT_TIM0 = 4'd1;
    localparam logic [3:0] SLOT_TIM1 = 4'd2;

    localparam logic [11:0] GPIO_OUT_OFS  = 12'h000;
    localparam logic [11:0] GPIO_IN_OFS   = 12'h004;
    localparam logic [11:0] GPIO_STAT_OFS = 12'h008; // write 1 to clear
    localparam logic [11:0] GPIO_IEN_OFS  = 12'h00C;

    localparam logic [11:0] TIM_CTRL_OFS  = 12'h000;
    localparam logic [11:0] TIM_LOAD_OFS  = 12'h004;
    localparam logic [11:0] TIM_COUNT_OFS = 12'h008; // read only
    localparam logic [11:0] TIM_STAT_OFS  = 12'h00C; // bit 0 expired, w1c

    localparam int unsigned CTRL_EN   = 0;
    localparam int unsigned CTRL_AUTO = 1;         // reload on expiry
    localparam int unsigned CTRL_IEN  = 2;

    // decoder looks at slot, register blocks at offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [15:0] unused;
            logic [3:0]  slot;
            logic [11:0] offset;
        } fld;
    } periph_addr_u;

endpackage : periph_pkg

`default_nettype wire

/* verilog/peripheral_bus.sv */
//////////////////////////////
// peripheral bus top
// AXI-lite slave port, slot decoder,
// GPIO block and two interval timers
// int_o = {tim1, tim0, gpio}
//////////////////////////////
`default_nettype none

module peripheral_bus #(
    parameter int unsigned NUM_GPIO_IN  = 8,
    parameter int unsigned NUM_GPIO_OUT = 8,
    parameter int unsigned TIMER_W      = 32
) (
    input  logic                          clock_i,
    input  logic                          rst_i,
    // AXI-lite slave from the host
    input  logic [periph_pkg::ADDR_W-1:0] s_axil_aw_addr_i,
    input  logic                          s_axil_aw_valid_i,
    output logic                          s_axil_aw_ready_o,
    input  logic [periph_pkg::DATA_W-1:0] s_axil_w_data_i,
    input  logic                          s_axil_w_valid_i,
    output logic                          s_axil_w_ready_o,
    output periph_pkg::axi_resp_e         s_axil_b_resp_o,
    output logic                          s_axil_b_valid_o,
    input  logic                          s_axil_b_ready_i,
    input  logic [periph_pkg::ADDR_W-1:0] s_axil_ar_addr_i,
    input  logic                          s_axil_ar_valid_i,
    output logic                          s_axil_ar_ready_o,
    output logic [periph_pkg::DATA_W-1:0] s_axil_r_data_o,
    output periph_pkg::axi_resp_e         s_axil_r_resp_o,
    output logic                          s_axil_r_valid_o,
    input  logic                          s_axil_r_ready_i,
    // pins
    input  logic [NUM_GPIO_IN-1:0]        gpio_in_i,
    output logic [NUM_GPIO_OUT-1:0]       gpio_out_o,
    output logic [2:0]                    int_o
);

    axilite_if gpio_bus ();                        // slot 0
    axilite_if tim0_bus ();                        // slot 1
    axilite_if tim1_bus ();                        // slot 2

    logic gpio_irq;
    logic tim0_irq;
    logic tim1_irq;

    assign int_o = {tim1_irq, tim0_irq, gpio_irq};

    periph_decoder decoder_u (
        .clock_i           ( clock_i           ),
        .rst_i             ( rst_i             ),
        .s_axil_aw_addr_i  ( s_axil_aw_addr_i  ),
        .s_axil_aw_valid_i ( s_axil_aw_valid_i ),
        .s_axil_aw_ready_o ( s_axil_aw_ready_o ),
        .s_axil_w_data_i   ( s_axil_w_data_i   ),
        .s_axil_w_valid_i  ( s_axil_w_valid_i  ),
        .s_axil_w_ready_o  ( s_axil_w_ready_o  ),
        .s_axil_b_resp_o   ( s_axil_b_resp_o   ),
        .s_axil_b_valid_o  ( s_axil_b_valid_o  ),
        .s_axil_b_ready_i  ( s_axil_b_ready_i  ),
        .s_axil_ar_addr_i  ( s_axil_ar_addr_i  ),
        .s_axil_ar_valid_i ( s_axil_ar_valid_i ),
        .s_axil_ar_ready_o ( s_axil_ar_ready_o ),
        .s_axil_r_data_o   ( s_axil_r_data_o   ),
        .s_axil_r_resp_o   ( s_axil_r_resp_o   ),
        .s_axil_r_valid_o  ( s_axil_r_valid_o  ),
        .s_axil_r_ready_i  ( s_axil_r_ready_i  ),
        .gpio_m            ( gpio_bus          ),
        .tim0_m            ( tim0_bus          ),
        .tim1_m            ( tim1_bus          )
    );

    gpio_regs #(
        .NUM_IN  ( NUM_GPIO_IN  ),
        .NUM_OUT ( NUM_GPIO_OUT )
    ) gpio_u (
        .clock_i    ( clock_i    ),
        .rst_i      ( rst_i      ),
        .bus_s      ( gpio_bus   ),
        .gpio_in_i  ( gpio_in_i  ),                // async pins, synced inside
        .gpio_out_o ( gpio_out_o ),
        .irq_o      ( gpio_irq   )
    );

    timer_regs #(.TIMER_W(TIMER_W)) tim0_u (
        .clock_i ( clock_i  ),
        .rst_i   ( rst_i    ),
        .bus_s   ( tim0_bus ),
        .irq_o   ( tim0_irq )
    );

    timer_regs #(.TIMER_W(TIMER_W)) tim1_u (
        .clock_i ( clock_i  ),
        .rst_i   ( rst_i    ),
        .bus_s   ( tim1_bus ),
        .irq_o   ( tim1_irq )
    );

endmodule : peripheral_bus

`default_nettype wire

/* verilog/timer_counter.sv */
//////////////////////////////
// timer down counter
// load, decrement, expiry pulse at zero
//////////////////////////////
`default_nettype none

module timer_counter #(
    parameter int unsigned TIMER_W = 32
) (
    input  logic               clock_i,
    input  logic               rst_i,
    input  logic               load_i,
    input  logic [TIMER_W-1:0] load_value_i,       // also the reload value
    input  logic               enable_i,
    input  logic               auto_reload_i,
    output logic [TIMER_W-1:0] count_o,
    output logic               expired_o
);

    logic [TIMER_W-1:0] count_q;

    assign count_o   = count_q;
    assign expired_o = enable_i & (count_q == '0);  // one cycle at zero

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;
        end else if (expired_o) begin
            if (auto_reload_i) begin
                count_q <= load_value_i;           // else hold at zero
            end
        end else if (enable_i) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule : timer_counter

`default_nettype wire

/* verilog/timer_regs.sv */
//////////////////////////////
// interval timer register block
// CTRL, LOAD, COUNT and STAT over AXI-lite
//////////////////////////////
`default_nettype none

module timer_regs #(
    parameter int unsigned TIMER_W = 32
) (
    input  logic     clock_i,
    input  logic     rst_i,
    axilite_if.slave bus_s,
    output logic     irq_o
);
    import periph_pkg::*;

    periph_addr_u        wr_addr;
    periph_addr_u        rd_addr;
    logic                wr_hs, rd_hs;
    logic                b_valid_q, r_valid_q;
    logic [DATA_W-1:0]   r_data_q;
    logic [DATA_W-1:0]   rd_word;
    logic [CTRL_IEN:0]   ctrl_q;                   // {ien, auto, en}
    logic [TIMER_W-1:0]  load_q;
    logic [TIMER_W-1:0]  load_value;
    logic [TIMER_W-1:0]  count;
    logic                stat_q;                   // expired flag
    logic                load_wr, ctrl_wr, stat_clr, expired;

    assign wr_addr.raw = bus_s.aw_addr;
    assign rd_addr.raw = bus_s.ar_addr;
    assign wr_hs = bus_s.aw_valid & bus_s.w_valid & ~b_valid_q;
    assign rd_hs = bus_s.ar_valid & ~r_valid_q;

    assign bus_s.aw_ready = wr_hs;
    assign bus_s.w_ready  = wr_hs;
    assign bus_s.b_valid  = b_valid_q;
    assign bus_s.b_resp   = RESP_OKAY;
    assign bus_s.ar_ready = rd_hs;
    assign bus_s.r_valid  = r_valid_q;
    assign bus_s.r_data   = r_data_q;
    assign bus_s.r_resp   = RESP_OKAY;

    assign load_wr    = wr_hs && (wr_addr.fld.offset == TIM_LOAD_OFS);
    assign ctrl_wr    = wr_hs && (wr_addr.fld.offset == TIM_CTRL_OFS);
    assign stat_clr   = wr_hs && (wr_addr.fld.offset == TIM_STAT_OFS) && bus_s.w_data[0];
    assign load_value = load_wr ? bus_s.w_data[TIMER_W-1:0] : load_q;  // write goes straight in
    assign irq_o      = stat_q & ctrl_q[CTRL_IEN];

    timer_counter #(.TIMER_W(TIMER_W)) counter_u (
        .clock_i       ( clock_i           ),
        .rst_i         ( rst_i             ),
        .load_i        ( load_wr           ),
        .load_value_i  ( load_value        ),
        .enable_i      ( ctrl_q[CTRL_EN]   ),
        .auto_reload_i ( ctrl_q[CTRL_AUTO] ),
        .count_o       ( count             ),
        .expired_o     ( expired           )
    );

    always_comb begin
        case (rd_addr.fld.offset)
            TIM_CTRL_OFS:  rd_word = DATA_W'(ctrl_q);
            TIM_LOAD_OFS:  rd_word = DATA_W'(load_q);
            TIM_COUNT_OFS: rd_word = DATA_W'(count);
            TIM_STAT_OFS:  rd_word = DATA_W'(stat_q);
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            ctrl_q    <= '0;
            load_q    <= '0;
            stat_q    <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
            r_data_q  <= '0;
        end else begin
            if (expired && !ctrl_q[CTRL_AUTO]) begin
                ctrl_q[CTRL_EN] <= 1'b0;           // one-shot stops itself
            end
            if (ctrl_wr) begin
                ctrl_q <= bus_s.w_data[CTRL_IEN:0];
            end
            if (load_wr) begin
                load_q <= bus_s.w_data[TIMER_W-1:0];
            end
            stat_q <= (stat_q & ~stat_clr) | expired;
            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (bus_s.b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_hs) begin
                r_valid_q <= 1'b1;
                r_data_q  <= rd_word;
            end else if (bus_s.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

endmodule : timer_regs

`default_nettype wire
